// ==== compile.f ====
+incdir+verif
source/fsync_pkg.sv
source/fsync_line_tree.sv
source/fsync_tile_port.sv
source/fsync_mesh.sv
verif/tb_clk_gen.sv
verif/tb_fsync_mesh.sv

// ==== source/fsync_line_tree.sv ====
/*
 * Barrier tree for one line of four tiles
 *
 * Collects arrival strobes from the members of a row or a column.
 * Two level-1 nodes join the neighbour pairs 0-1 and 2-3, one level-2
 * node joins all four members. A full node clears its arrival bits and
 * wakes its members one cycle after the completing strobe.
 */

module fsync_line_tree
  import fsync_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  line_mask_t req_i,            // Arrival strobes, one per member
  input  lvl_t       lvl_i [N_LINE],   // Level of each strobe
  output line_mask_t wake_o            // Wake pulses, one per member
);

  localparam int unsigned N_PAIR = N_LINE / 2;    // Level-1 nodes in the line

  line_mask_t                 l1_hit;     // Strobes aimed at a pair node
  line_mask_t                 l2_hit;     // Strobes aimed at the line node

  logic [N_PAIR-1:0][1:0]     l1_arr_q;   // Pair node arrival bits
  logic [N_PAIR-1:0][1:0]     l1_arr_d;
  line_mask_t                 l2_arr_q;   // Line node arrival bits
  line_mask_t                 l2_arr_d;

  line_mask_t                 wake_d;
  line_mask_t                 wake_q;

  // Route each strobe to the node its level selects
  always_comb begin
    for (int m = 0; m < N_LINE; m++) begin
      l1_hit[m] = req_i[m] && (lvl_i[m] == lvl_t'(1));
      l2_hit[m] = req_i[m] && (lvl_i[m] == lvl_t'(MAX_LVL));
    end
  end

  // A full node empties and wakes its members
  always_comb begin
    wake_d   = '0;
    l2_arr_d = l2_arr_q | l2_hit;
    if (&l2_arr_d) begin
      wake_d   = '1;                      // Whole line arrived
      l2_arr_d = '0;
    end

    for (int p = 0; p < N_PAIR; p++) begin
      l1_arr_d[p] = l1_arr_q[p] | l1_hit[2*p +: 2];
      if (&l1_arr_d[p]) begin
        wake_d[2*p +: 2] = 2'b11;         // Both neighbours arrived
        l1_arr_d[p]      = '0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      l1_arr_q <= '0;
      l2_arr_q <= '0;
      wake_q   <= '0;
    end else begin
      l1_arr_q <= l1_arr_d;
      l2_arr_q <= l2_arr_d;
      wake_q   <= wake_d;
    end
  end

  assign wake_o = wake_q;

  // The tile ports must never send a duplicate arrival or a bad level
  for (genvar m = 0; m < N_LINE; m++) begin : gen_chk
    a_no_dup_arrival : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      (l1_hit[m] |-> !l1_arr_q[m/2][m%2]) and (l2_hit[m] |-> !l2_arr_q[m])
    ) else $error("Member %0d arrived twice at the same node", m);

    a_lvl_range : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      req_i[m] |-> (lvl_i[m] != '0) && (lvl_i[m] <= lvl_t'(MAX_LVL))
    ) else $error("Member %0d strobed with level %0d", m, lvl_i[m]);
  end

endmodule : fsync_line_tree

// ==== source/fsync_mesh.sv ====
/*
 * Synchronization network for a 4x4 tile mesh
 *
 * One port per tile feeds a row tree and a column tree that work side
 * by side. Each port takes back the wake of the tree it is waiting on.
 */

module fsync_mesh
  import fsync_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  tile_mask_t sync_req_i,             // Request strobe per tile
  input  tile_mask_t sync_dir_i,             // Direction per tile
  input  lvl_t       sync_lvl_i [N_TILES],   // Level per tile
  output tile_mask_t wake_o,
  output tile_mask_t error_o,
  output tile_mask_t busy_o
);

  // Tile side
  tile_mask_t h_req;                         // Strobes into the row trees
  tile_mask_t v_req;                         // Strobes into the column trees
  tile_mask_t h_wake;                        // Row tree wake per tile
  tile_mask_t v_wake;                        // Column tree wake per tile
  lvl_t       tile_lvl [N_TILES];

  // Member index is the column in a row tree and the row in a column tree
  line_mask_t row_req  [N_TILES_Y];
  line_mask_t row_wake [N_TILES_Y];
  lvl_t       row_lvl  [N_TILES_Y][N_LINE];
  line_mask_t col_req  [N_TILES_X];
  line_mask_t col_wake [N_TILES_X];
  lvl_t       col_lvl  [N_TILES_X][N_LINE];

  for (genvar i = 0; i < N_TILES_Y; i++) begin : gen_y_tile
    for (genvar j = 0; j < N_TILES_X; j++) begin : gen_x_tile
      localparam int unsigned K = i * N_TILES_X + j;  // Tile index

      fsync_tile_port i_tile_port (
        .clk_i                            ,
        .rst_n_i                          ,
        .sync_req_i ( sync_req_i[K]      ),
        .sync_dir_i ( sync_dir_i[K]      ),
        .sync_lvl_i ( sync_lvl_i[K]      ),
        .h_req_o    ( h_req[K]           ),
        .v_req_o    ( v_req[K]           ),
        .lvl_o      ( tile_lvl[K]        ),
        .h_wake_i   ( h_wake[K]          ),
        .v_wake_i   ( v_wake[K]          ),
        .wake_o     ( wake_o[K]          ),
        .error_o    ( error_o[K]         ),
        .busy_o     ( busy_o[K]          )
      );

      // Tile to line member mapping
      assign row_req[i][j] = h_req[K];
      assign row_lvl[i][j] = tile_lvl[K];
      assign col_req[j][i] = v_req[K];
      assign col_lvl[j][i] = tile_lvl[K];
      assign h_wake[K]     = row_wake[i][j];
      assign v_wake[K]     = col_wake[j][i];
    end
  end

  for (genvar i = 0; i < N_TILES_Y; i++) begin : gen_row_tree
    fsync_line_tree i_row_tree (
      .clk_i                    ,
      .rst_n_i                  ,
      .req_i   ( row_req[i]    ),
      .lvl_i   ( row_lvl[i]    ),
      .wake_o  ( row_wake[i]   )
    );
  end

  for (genvar j = 0; j < N_TILES_X; j++) begin : gen_col_tree
    fsync_line_tree i_col_tree (
      .clk_i                    ,
      .rst_n_i                  ,
      .req_i   ( col_req[j]    ),
      .lvl_i   ( col_lvl[j]    ),
      .wake_o  ( col_wake[j]   )
    );
  end

endmodule : fsync_mesh

// ==== source/fsync_pkg.sv ====
/*
 * Synchronization network package
 *
 * Mesh dimensions, barrier level limits and the types shared by the
 * tile ports, the line trees and the mesh top.
 */

package fsync_pkg;

  // Mesh geometry
  localparam int unsigned N_TILES_X = 4;                      // Mesh columns
  localparam int unsigned N_TILES_Y = 4;                      // Mesh rows
  localparam int unsigned N_TILES   = N_TILES_X * N_TILES_Y;  // Tiles in the mesh
  localparam int unsigned N_LINE    = 4;                      // Tiles per row or column

  // Barrier levels
  // Level 1 joins a neighbour pair and level 2 a whole line
  localparam int unsigned MAX_LVL = 2;                        // Highest barrier level

  // One bit per tile at index row * N_TILES_X + column
  typedef logic [N_TILES-1:0] tile_mask_t;

  // One bit per member of a row or column
  typedef logic [N_LINE-1:0] line_mask_t;

  // Barrier level where only 1 and 2 are valid
  typedef logic [1:0] lvl_t;

  // Direction 0 is horizontal (row) and 1 is vertical (column)
  typedef logic fsync_dir_t;

  // Tile port FSM
  typedef enum logic [1:0] {
    PORT_IDLE   = 2'd0,    // No barrier pending
    PORT_WAIT_H = 2'd1,    // Waiting on the row tree
    PORT_WAIT_V = 2'd2     // Waiting on the column tree
  } port_state_e;

endpackage : fsync_pkg

// ==== source/fsync_tile_port.sv ====
/*
 * Per-tile barrier port
 *
 * Checks each barrier request, routes a valid one to the row or column
 * tree and waits for the wake of that direction. Invalid levels and
 * requests made while a barrier is pending are answered with error.
 */

module fsync_tile_port
  import fsync_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       sync_req_i,    // Barrier request strobe
  input  fsync_dir_t sync_dir_i,    // 0 for row, 1 for column
  input  lvl_t       sync_lvl_i,    // Requested level
  output logic       h_req_o,       // Strobe to the row tree
  output logic       v_req_o,       // Strobe to the column tree
  output lvl_t       lvl_o,         // Level sent with the strobe
  input  logic       h_wake_i,      // Wake from the row tree
  input  logic       v_wake_i,      // Wake from the column tree
  output logic       wake_o,
  output logic       error_o,
  output logic       busy_o
);

  port_state_e state_q;
  port_state_e state_d;

  logic lvl_ok;                     // Level is within 1..MAX_LVL
  logic accept;                     // Valid request taken in idle
  logic h_req_d;
  logic v_req_d;
  logic wake_d;
  logic error_d;

  assign lvl_ok = (sync_lvl_i != '0) && (sync_lvl_i <= lvl_t'(MAX_LVL));

  always_comb begin
    state_d = state_q;
    accept  = 1'b0;
    h_req_d = 1'b0;
    v_req_d = 1'b0;
    wake_d  = 1'b0;
    error_d = 1'b0;

    unique case (state_q)
      PORT_IDLE: begin
        if (sync_req_i) begin
          if (!lvl_ok) begin
            error_d = 1'b1;         // Level 0 or above the top level
          end else if (sync_dir_i) begin
            accept  = 1'b1;
            v_req_d = 1'b1;
            state_d = PORT_WAIT_V;
          end else begin
            accept  = 1'b1;
            h_req_d = 1'b1;
            state_d = PORT_WAIT_H;
          end
        end
      end

      PORT_WAIT_H: begin
        error_d = sync_req_i;       // Only one barrier in flight
        if (h_wake_i) begin
          wake_d  = 1'b1;
          state_d = PORT_IDLE;
        end
      end

      PORT_WAIT_V: begin
        error_d = sync_req_i;
        if (v_wake_i) begin
          wake_d  = 1'b1;
          state_d = PORT_IDLE;
        end
      end

      default: state_d = PORT_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= PORT_IDLE;
      h_req_o <= 1'b0;
      v_req_o <= 1'b0;
      wake_o  <= 1'b0;
      error_o <= 1'b0;
    end else begin
      state_q <= state_d;
      h_req_o <= h_req_d;
      v_req_o <= v_req_d;
      wake_o  <= wake_d;
      error_o <= error_d;
    end
  end

  // Level held for the tree strobe
  always_ff @(posedge clk_i) begin
    if (accept) begin
      lvl_o <= sync_lvl_i;
    end
  end

  assign busy_o = (state_q != PORT_IDLE);

  a_one_tree : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !(h_req_o && v_req_o)
  ) else $error("Strobe sent to both trees");

  // Wake ends a pending barrier and leaves the port idle
  a_wake_from_wait : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    wake_o |-> ($past(state_q) inside {PORT_WAIT_H, PORT_WAIT_V}) && !busy_o
  ) else $error("Wake without a pending barrier");

endmodule : fsync_tile_port

// ==== verif/tb_clk_gen.sv ====
/*
 * Testbench clock and reset generator
 *
 * Free running clock and an active low reset that is held for a fixed
 * number of cycles and released on a falling edge.
 */

module tb_clk_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_n_o
);

  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;                 // Release away from the sampling edge
  end

endmodule : tb_clk_gen

// ==== verif/tb_fsync_tasks.svh ====
/*
 * Directed tests and check helpers for the synchronization network
 *
 * Every task starts and ends on a falling clock edge. Requests are set
 * up on that edge and cleared on the next one.
 */

`ifndef TB_FSYNC_TASKS_SVH
`define TB_FSYNC_TASKS_SVH

task automatic abort_run(input string why);
  $display("%s", why);
  $display("Simulation failed");
  $fatal(1, "Run stopped at the first error");
endtask

function automatic int tile_index(input int row, input int col);
  return row * N_TILES_X + col;
endfunction

function automatic tile_mask_t tile_bit(input int row, input int col);
  tile_mask_t m;
  m = '0;
  m[tile_index(row, col)] = 1'b1;
  return m;
endfunction

task automatic check_mask(input string name, input tile_mask_t act, input tile_mask_t exp);
  assert (act === exp) else begin
    abort_run($sformatf("Error: %s expected %h actual %h", name, exp, act));
  end
endtask

task automatic check_outputs(input tile_mask_t exp_wake, input tile_mask_t exp_error,
                             input tile_mask_t exp_busy);
  check_mask("wake_o", wake, exp_wake);
  check_mask("error_o", error, exp_error);
  check_mask("busy_o", busy, exp_busy);
endtask

task automatic raise_request(input int k, input fsync_dir_t dir, input lvl_t lvl);
  sync_req[k] = 1'b1;
  sync_dir[k] = dir;
  sync_lvl[k] = lvl;
endtask

// Requests are one-cycle strobes
task automatic next_cycle();
  @(negedge clk);
  sync_req = '0;
  sync_dir = '0;
  foreach (sync_lvl[k]) begin
    sync_lvl[k] = '0;
  end
endtask

task automatic quiet_cycles(input int n, input tile_mask_t exp_busy);
  repeat (n) begin
    @(negedge clk);
    check_outputs('0, '0, exp_busy);
  end
endtask

// Called on the falling edge right after the completing request was sampled
task automatic await_wake(input tile_mask_t exp_wake, input tile_mask_t exp_busy);
  int cycles;
  cycles = 0;
  check_mask("wake_o", wake, '0);
  while (wake === '0 && cycles < WAKE_LIMIT) begin
    @(negedge clk);
    cycles++;
  end
  assert (wake !== '0) else begin
    abort_run($sformatf("No wake pulse seen within %0d cycles", WAKE_LIMIT));
  end
  check_mask("wake_o", wake, exp_wake);
  assert (cycles == WAKE_LATENCY) else begin
    abort_run($sformatf("Error: wake_o latency expected %h actual %h",
                        WAKE_LATENCY, cycles));
  end
  check_mask("busy_o", busy, exp_busy);     // Busy drops as wake rises
  @(negedge clk);
  check_outputs('0, '0, exp_busy);          // Single cycle pulse
endtask

task automatic reset_state();
  $display("Test: reset state");
  check_outputs('0, '0, '0);
  quiet_cycles(2, '0);
endtask

task automatic row_pair_level1();
  tile_mask_t pair;
  $display("Test: level-1 row pair");
  pair = tile_bit(0, 0) | tile_bit(0, 1);
  raise_request(tile_index(0, 0), 1'b0, lvl_t'(1));
  next_cycle();
  check_outputs('0, '0, tile_bit(0, 0));
  quiet_cycles(3, tile_bit(0, 0));          // Tile 0 waits alone
  raise_request(tile_index(0, 1), 1'b0, lvl_t'(1));
  next_cycle();
  check_outputs('0, '0, pair);
  await_wake(pair, '0);
endtask

task automatic column_level2();
  int         order [N_LINE];
  int         j;
  int         tmp;
  int         col;
  tile_mask_t col_mask;
  tile_mask_t pair;
  tile_mask_t pending;
  $display("Test: level-2 column in random order");
  col = 2;
  for (int r = 0; r < N_LINE; r++) begin
    order[r] = r;
  end
  for (int i = N_LINE - 1; i > 0; i--) begin
    j        = $unsigned($random(seed)) % (i + 1);
    tmp      = order[i];
    order[i] = order[j];
    order[j] = tmp;
  end
  col_mask = '0;
  for (int r = 0; r < N_LINE; r++) begin
    col_mask |= tile_bit(r, col);
  end
  pair    = tile_bit(0, 0) | tile_bit(0, 1);  // Row pair outside the column
  pending = '0;
  for (int n = 0; n < N_LINE; n++) begin
    raise_request(tile_index(order[n], col), 1'b1, lvl_t'(2));
    pending |= tile_bit(order[n], col);
    if (n == 0) begin
      raise_request(tile_index(0, 0), 1'b0, lvl_t'(1));
      pending |= tile_bit(0, 0);
    end
    if (n == N_LINE - 1) begin
      raise_request(tile_index(0, 1), 1'b0, lvl_t'(1));   // Completes with the column
      pending |= tile_bit(0, 1);
    end
    next_cycle();
    check_outputs('0, '0, pending);
    if (n < N_LINE - 1) begin
      quiet_cycles(1, pending);
    end
  end
  await_wake(col_mask | pair, '0);
endtask

task automatic level_mix();
  tile_mask_t t5;
  tile_mask_t row1;
  $display("Test: level mix in one row");
  t5   = tile_bit(1, 1);
  row1 = tile_bit(1, 0) | tile_bit(1, 1) | tile_bit(1, 2) | tile_bit(1, 3);
  raise_request(tile_index(1, 1), 1'b0, lvl_t'(2));
  next_cycle();
  check_outputs('0, '0, t5);
  quiet_cycles(2, t5);
  // Other pair of row 1 closes a level-1 barrier while tile 5 waits
  raise_request(tile_index(1, 2), 1'b0, lvl_t'(1));
  next_cycle();
  check_outputs('0, '0, t5 | tile_bit(1, 2));
  raise_request(tile_index(1, 3), 1'b0, lvl_t'(1));
  next_cycle();
  check_outputs('0, '0, t5 | tile_bit(1, 2) | tile_bit(1, 3));
  await_wake(tile_bit(1, 2) | tile_bit(1, 3), t5);
  quiet_cycles(2, t5);
  // Rest of the row joins tile 5 at level 2
  raise_request(tile_index(1, 0), 1'b0, lvl_t'(2));
  raise_request(tile_index(1, 2), 1'b0, lvl_t'(2));
  raise_request(tile_index(1, 3), 1'b0, lvl_t'(2));
  next_cycle();
  check_outputs('0, '0, row1);
  await_wake(row1, '0);
endtask

task automatic request_errors();
  tile_mask_t t9;
  $display("Test: invalid requests");
  t9 = tile_bit(2, 1);
  raise_request(tile_index(2, 1), 1'b0, lvl_t'(0));
  next_cycle();
  check_outputs('0, t9, '0);
  quiet_cycles(1, '0);
  raise_request(tile_index(2, 1), 1'b1, lvl_t'(3));
  next_cycle();
  check_outputs('0, t9, '0);
  quiet_cycles(1, '0);
  raise_request(tile_index(2, 1), 1'b0, lvl_t'(1));
  next_cycle();
  check_outputs('0, '0, t9);
  raise_request(tile_index(2, 1), 1'b1, lvl_t'(2));    // Second barrier while busy
  next_cycle();
  check_outputs('0, t9, t9);
  quiet_cycles(2, t9);
  raise_request(tile_index(2, 0), 1'b0, lvl_t'(1));
  next_cycle();
  check_outputs('0, '0, t9 | tile_bit(2, 0));
  await_wake(t9 | tile_bit(2, 0), '0);
endtask

`endif

// ==== verif/tb_fsync_mesh.sv ====
/*
 * Testbench for the synchronization network
 *
 * Drives barrier requests into the 4x4 mesh on the falling clock edge
 * and checks wake, error and busy against the expected barrier timing.
 * A watchdog bounds the run.
 */

module tb_fsync_mesh
  import fsync_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 5;
  localparam int WAKE_LATENCY = 2;    // Last sampling edge to wake_o
  localparam int WAKE_LIMIT   = 8;    // Cycles to wait before giving up

  // Cycle budget of each test
  localparam int T_RESET   = 4;
  localparam int T_PAIR    = 16;
  localparam int T_COLUMN  = 24;
  localparam int T_MIX     = 30;
  localparam int T_ERRORS  = 24;
  localparam int T_MARGIN  = 100;
  localparam int WATCHDOG_NS = (RESET_CYCLES + T_RESET + T_PAIR + T_COLUMN + T_MIX
                                + T_ERRORS + T_MARGIN) * CLK_PERIOD;

  logic       clk;
  logic       rst_n;
  tile_mask_t sync_req;
  tile_mask_t sync_dir;
  lvl_t       sync_lvl [N_TILES];
  tile_mask_t wake;
  tile_mask_t error;
  tile_mask_t busy;

  integer     seed;                   // Seed for the random request order

  tb_clk_gen #(
    .PERIOD_NS    ( CLK_PERIOD   ),
    .RESET_CYCLES ( RESET_CYCLES )
  ) i_clk_gen (
    .clk_o   ( clk   ),
    .rst_n_o ( rst_n )
  );

  fsync_mesh UUT (
    .clk_i      ( clk      ),
    .rst_n_i    ( rst_n    ),
    .sync_req_i ( sync_req ),
    .sync_dir_i ( sync_dir ),
    .sync_lvl_i ( sync_lvl ),
    .wake_o     ( wake     ),
    .error_o    ( error    ),
    .busy_o     ( busy     )
  );

  `include "tb_fsync_tasks.svh"

  initial begin
    sync_req = '0;
    sync_dir = '0;
    foreach (sync_lvl[k]) begin
      sync_lvl[k] = '0;
    end
    seed = 32'he32d_ef0b;

    @(posedge rst_n);                 // Released on a falling edge

    reset_state();
    row_pair_level1();
    column_level2();
    level_mix();
    request_errors();

    $display("Simulation passed");
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    abort_run($sformatf("Timeout: tests still running after %0d ns", WATCHDOG_NS));
  end

endmodule : tb_fsync_mesh
